// ==== source/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

        localparam int block_bits = 128;
        localparam int byte_bits = 8;
        localparam int num_rounds = 10;         // 11 round keys
        localparam int key_index_bits = 4;

        // control fsm states
        localparam logic [1:0] fsm_idle = 2'd0;
        localparam logic [1:0] fsm_expand = 2'd1;
        localparam logic [1:0] fsm_round = 2'd2;
        localparam logic [1:0] fsm_finish = 2'd3;

        // step codes driven to the round datapath
        localparam logic [1:0] step_add_key = 2'd0;
        localparam logic [1:0] step_shift_rows = 2'd1;
        localparam logic [1:0] step_sub_bytes = 2'd2;
        localparam logic [1:0] step_mix_columns = 2'd3;

        localparam logic [byte_bits-1:0] gf_poly = 8'h1b;      // x^8 + x^4 + x^3 + x + 1

        // entry 0 sits in the top byte, one row of 16 entries per line
        localparam logic [256*byte_bits-1:0] sbox_table = {
                128'h637c777bf26b6fc53001672bfed7ab76,
                128'hca82c97dfa5947f0add4a2af9ca472c0,
                128'hb7fd9326363ff7cc34a5e5f171d83115,
                128'h04c723c31896059a071280e2eb27b275,
                128'h09832c1a1b6e5aa0523bd6b329e32f84,
                128'h53d100ed20fcb15b6acbbe394a4c58cf,
                128'hd0efaafb434d338545f9027f503c9fa8,
                128'h51a3408f929d38f5bcb6da2110fff3d2,
                128'hcd0c13ec5f974417c4a77e3d645d1973,
                128'h60814fdc222a908846eeb814de5e0bdb,
                128'he0323a0a4906245cc2d3ac629195e479,
                128'he7c8376d8dd54ea96c56f4ea657aae08,
                128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
                128'h703eb5664803f60e613557b986c11d9e,
                128'he1f8981169d98e949b1e87e9ce5528df,
                128'h8ca1890dbfe6426841992d0fb054bb16
        };

        localparam logic [256*byte_bits-1:0] inv_sbox_table = {
                128'h52096ad53036a538bf40a39e81f3d7fb,
                128'h7ce339829b2fff87348e4344c4dee9cb,
                128'h547b9432a6c2233dee4c950b42fac34e,
                128'h082ea16628d924b2765ba2496d8bd125,
                128'h72f8f66486689816d4a45ccc5d65b692,
                128'h6c704850fdedb9da5e154657a78d9d84,
                128'h90d8ab008cbcd30af7e45805b8b34506,
                128'hd02c1e8fca3f0f02c1afbd0301138a6b,
                128'h3a9111414f67dcea97f2cfcef0b4e673,
                128'h96ac7422e7ad3585e2f937e81c75df6e,
                128'h47f11a711d29c5896fb7620eaa18be1b,
                128'hfc563e4bc6d279209adbc0fe78cd5af4,
                128'h1fdda8338807c731b11210592780ec5f,
                128'h60517fa919b54a0d2de57a9f93c99cef,
                128'ha0e03b4dae2af5b0c8ebbb3c83539961,
                128'h172b047eba77d626e169146355210c7d
        };

        // rcon for key 1 in the top byte
        localparam logic [num_rounds*byte_bits-1:0] rcon_table = 80'h01020408102040801b36;

        // byte i at bits 8i+7:8i, column c holds bytes 4c to 4c+3
        typedef union packed {
                logic [block_bits/byte_bits-1:0][byte_bits-1:0] bytes;
                logic [3:0][4*byte_bits-1:0] cols;
        } aes_block_u;

        function automatic logic [byte_bits-1:0] xtime(input logic [byte_bits-1:0] b);
                xtime = {b[byte_bits-2:0], 1'b0} ^ (b[byte_bits-1] ? gf_poly : '0);
        endfunction

endpackage

`default_nettype wire

// ==== source/aes_inv_mix_column.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_inv_mix_column (
        input  logic [4*aes_pkg::byte_bits-1:0]        column_in,
        output logic [4*aes_pkg::byte_bits-1:0]        column_out
);

        logic [3:0][aes_pkg::byte_bits-1:0] a;
        logic [3:0][aes_pkg::byte_bits-1:0] x2;
        logic [3:0][aes_pkg::byte_bits-1:0] x4;
        logic [3:0][aes_pkg::byte_bits-1:0] x8;
        logic [3:0][aes_pkg::byte_bits-1:0] res;

        assign a = column_in;

        always_comb begin
                for (int i = 0; i < 4; i++) begin
                        x2[i] = aes_pkg::xtime(a[i]);
                        x4[i] = aes_pkg::xtime(x2[i]);
                        x8[i] = aes_pkg::xtime(x4[i]);
                end
                // row r: 0e, 0b, 0d, 09 starting at byte r
                for (int r = 0; r < 4; r++) begin
                        res[r] = (x8[r] ^ x4[r] ^ x2[r]) ^
                                 (x8[(r+1)%4] ^ x2[(r+1)%4] ^ a[(r+1)%4]) ^
                                 (x8[(r+2)%4] ^ x4[(r+2)%4] ^ a[(r+2)%4]) ^
                                 (x8[(r+3)%4] ^ a[(r+3)%4]);
                end
        end

        assign column_out = res;

endmodule

`default_nettype wire

// ==== source/aes_inv_round.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_inv_round (
        input  logic                                   clk,
        input  logic                                   rst,
        input  logic                                   start,
        input  logic [aes_pkg::block_bits-1:0]         data,
        input  logic [1:0]                             step,
        input  aes_pkg::aes_block_u                    round_key,
        output aes_pkg::aes_block_u                    state
);

        aes_pkg::aes_block_u shifted;
        aes_pkg::aes_block_u subbed;
        aes_pkg::aes_block_u keyed;
        logic [3:0][4*aes_pkg::byte_bits-1:0] mixed_cols;

        // row r of column c comes from column c - r
        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                shifted.bytes[4*c + r] = state.bytes[4*((c + 4 - r) % 4) + r];
                        end
                end
        end

        always_comb begin
                for (int i = 0; i < 16; i++) begin
                        subbed.bytes[i] = aes_pkg::inv_sbox_table[{~state.bytes[i], 3'b000} +:
                                                                  aes_pkg::byte_bits];
                end
        end

        assign keyed = state ^ round_key;

        for (genvar c = 0; c < 4; c++) begin : g_mix
                aes_inv_mix_column u_mix (
                        .column_in  (state.cols[c]),
                        .column_out (mixed_cols[c])
                );
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= '0;
                end else if (start) begin
                        state <= data;
                end else begin
                        case (step)
                        aes_pkg::step_add_key: state <= keyed;
                        aes_pkg::step_shift_rows: state <= shifted;
                        aes_pkg::step_sub_bytes: state <= subbed;
                        aes_pkg::step_mix_columns: state <= mixed_cols;
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== source/aes_key_expander.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_key_expander (
        input  logic                                   clk,
        input  logic                                   rst,
        input  logic                                   start,
        input  logic [aes_pkg::block_bits-1:0]         key,
        input  logic [aes_pkg::key_index_bits-1:0]     key_index,
        output aes_pkg::aes_block_u                    round_key,
        output logic                                   keys_ready
);

        aes_pkg::aes_block_u keys [0:aes_pkg::num_rounds];
        aes_pkg::aes_block_u prev_key;
        aes_pkg::aes_block_u next_key;
        logic [aes_pkg::key_index_bits-1:0] exp_count;  // key being derived, 0 when done
        logic [4*aes_pkg::byte_bits-1:0] rot_word;
        logic [4*aes_pkg::byte_bits-1:0] sub_word;
        logic [aes_pkg::byte_bits-1:0] rcon;

        assign prev_key = keys[exp_count - 1'b1];
        assign rot_word = {prev_key.cols[3][7:0], prev_key.cols[3][31:8]};
        assign rcon = aes_pkg::rcon_table[(aes_pkg::num_rounds - exp_count) *
                                          aes_pkg::byte_bits +: aes_pkg::byte_bits];

        always_comb begin
                for (int i = 0; i < 4; i++) begin
                        sub_word[8*i +: 8] = aes_pkg::sbox_table[{~rot_word[8*i +: 8], 3'b000} +:
                                                                 aes_pkg::byte_bits];
                end
        end

        // xor chain across the four words
        always_comb begin
                next_key.cols[0] = prev_key.cols[0] ^ sub_word ^ {24'd0, rcon};
                next_key.cols[1] = prev_key.cols[1] ^ next_key.cols[0];
                next_key.cols[2] = prev_key.cols[2] ^ next_key.cols[1];
                next_key.cols[3] = prev_key.cols[3] ^ next_key.cols[2];
        end

        always_ff @(posedge clk) begin
                if (start) begin
                        keys[0] <= key;
                end else if (exp_count != '0) begin
                        keys[exp_count] <= next_key;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        exp_count <= '0;
                        keys_ready <= 1'b0;
                end else if (start) begin
                        exp_count <= 4'd1;
                        keys_ready <= 1'b0;
                end else if (exp_count != '0) begin
                        if (exp_count == aes_pkg::num_rounds) begin
                                exp_count <= '0;
                                keys_ready <= 1'b1;     // key 10 written this edge
                        end else begin
                                exp_count <= exp_count + 1'b1;
                        end
                end
        end

        assign round_key = keys[key_index];

endmodule

`default_nettype wire

// ==== source/aes_inv_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_inv_control (
        input  logic                                   clk,
        input  logic                                   rst,
        input  logic                                   read_en,
        input  logic                                   keys_ready,
        output logic                                   start,
        output logic                                   finish,
        output logic [1:0]                             step,
        output logic [aes_pkg::key_index_bits-1:0]     key_index
);

        logic [1:0] fsm;
        logic [1:0] phase;                              // step code inside a round
        logic [aes_pkg::key_index_bits-1:0] round_cnt;
        logic expand_done;

        assign expand_done = keys_ready && !start;      // keys_ready is stale while start is high

        always_ff @(posedge clk) begin
                if (rst) begin
                        fsm <= aes_pkg::fsm_idle;
                        phase <= aes_pkg::step_add_key;
                        round_cnt <= '0;
                        start <= 1'b0;
                end else begin
                        start <= 1'b0;
                        case (fsm)
                        aes_pkg::fsm_idle: begin
                                if (read_en) begin
                                        fsm <= aes_pkg::fsm_expand;
                                        start <= 1'b1;
                                end
                        end
                        aes_pkg::fsm_expand: begin
                                if (expand_done) begin
                                        fsm <= aes_pkg::fsm_round;
                                        phase <= aes_pkg::step_shift_rows;
                                        round_cnt <= 4'd1;
                                end
                        end
                        aes_pkg::fsm_round: begin
                                case (phase)
                                aes_pkg::step_shift_rows: phase <= aes_pkg::step_sub_bytes;
                                aes_pkg::step_sub_bytes: phase <= aes_pkg::step_add_key;
                                aes_pkg::step_add_key: begin
                                        if (round_cnt == aes_pkg::num_rounds) begin
                                                fsm <= aes_pkg::fsm_finish;  // no mix in last round
                                        end else begin
                                                phase <= aes_pkg::step_mix_columns;
                                        end
                                end
                                default: begin
                                        phase <= aes_pkg::step_shift_rows;
                                        round_cnt <= round_cnt + 1'b1;
                                end
                                endcase
                        end
                        default: fsm <= aes_pkg::fsm_idle;
                        endcase
                end
        end

        // while expanding, key 0 is xor'ed an even number of times and the state is unchanged;
        // the cycle keys_ready is seen performs the initial add of key 10
        always_comb begin
                step = aes_pkg::step_add_key;
                key_index = '0;
                case (fsm)
                aes_pkg::fsm_expand: begin
                        if (expand_done) begin
                                key_index = aes_pkg::key_index_bits'(aes_pkg::num_rounds);
                        end
                end
                aes_pkg::fsm_round: begin
                        step = phase;
                        key_index = aes_pkg::key_index_bits'(aes_pkg::num_rounds) - round_cnt;
                end
                default: ;
                endcase
        end

        assign finish = (fsm == aes_pkg::fsm_finish);

endmodule

`default_nettype wire

// ==== source/aes_result_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_result_stage (
        input  logic                                   clk,
        input  logic                                   rst,
        input  logic                                   start,
        input  logic                                   finish,
        input  aes_pkg::aes_block_u                    state,
        output logic [aes_pkg::block_bits-1:0]         out_data,
        output logic                                   done
);

        // plaintext held here while the datapath keeps stepping
        always_ff @(posedge clk) begin
                if (finish) begin
                        out_data <= state;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        done <= 1'b0;
                end else if (finish) begin
                        done <= 1'b1;
                end else if (start) begin
                        done <= 1'b0;   // next block accepted
                end
        end

endmodule

`default_nettype wire

// ==== source/aes_inv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_inv_top (
        input  logic                                   clk,
        input  logic                                   rst,
        input  logic                                   read_en,
        input  logic [aes_pkg::block_bits-1:0]         data,
        input  logic [aes_pkg::block_bits-1:0]         key,
        output logic                                   done,
        output logic [aes_pkg::block_bits-1:0]         out_data
);

        logic start;
        logic finish;
        logic keys_ready;
        logic [1:0] step;
        logic [aes_pkg::key_index_bits-1:0] key_index;
        aes_pkg::aes_block_u round_key;
        aes_pkg::aes_block_u state;

        aes_key_expander u_key_expander (
                .clk        (clk),
                .rst        (rst),
                .start      (start),
                .key        (key),
                .key_index  (key_index),
                .round_key  (round_key),
                .keys_ready (keys_ready)
        );

        aes_inv_control u_control (
                .clk        (clk),
                .rst        (rst),
                .read_en    (read_en),
                .keys_ready (keys_ready),
                .start      (start),
                .finish     (finish),
                .step       (step),
                .key_index  (key_index)
        );

        aes_inv_round u_round (
                .clk        (clk),
                .rst        (rst),
                .start      (start),
                .data       (data),
                .step       (step),
                .round_key  (round_key),
                .state      (state)
        );

        aes_result_stage u_result (
                .clk        (clk),
                .rst        (rst),
                .start      (start),
                .finish     (finish),
                .state      (state),
                .out_data   (out_data),
                .done       (done)
        );

endmodule

`default_nettype wire

// ==== testbench/aes_inv_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_inv_tb;

        localparam int max_vectors = 32;
        localparam int latency = 52;            // read_en edge to done
        localparam int wait_limit = 64;
        localparam int decoy_cycle = 20;

        logic clk;
        logic rst;
        logic read_en;
        logic [aes_pkg::block_bits-1:0] data;
        logic [aes_pkg::block_bits-1:0] key;
        logic done;
        logic [aes_pkg::block_bits-1:0] out_data;

        // four words per vector: key, ciphertext, plaintext, decoy flag
        logic [aes_pkg::block_bits-1:0] trace_mem [0:4*max_vectors-1];
        int num_vectors;
        logic loaded = 1'b0;
        integer seed;
        int value_errors;
        int timing_errors;
        int other_errors;
        logic prev_done;
        logic [aes_pkg::block_bits-1:0] held_data;

        aes_inv_top UUT (
                .clk      (clk),
                .rst      (rst),
                .read_en  (read_en),
                .data     (data),
                .key      (key),
                .done     (done),
                .out_data (out_data)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        initial begin
                wait (loaded === 1'b1);
                repeat (num_vectors * 70 + 20) @(posedge clk);
                $display("timeout: the run did not end within %0d clock periods",
                         num_vectors * 70 + 20);
                $display("errors: %0d value, %0d timing, %0d other",
                         value_errors, timing_errors, other_errors);
                $display("Result: FAILED");
                $finish;
        end

        task automatic load_trace;
                int i;
                for (i = 0; i < 4*max_vectors; i++) begin
                        trace_mem[i] = {4{~32'(i)}};    // never a valid flag
                end
                $readmemh("testbench/aes_inv_trace.txt", trace_mem);
                num_vectors = 0;
                while (num_vectors < max_vectors && trace_mem[4*num_vectors + 3] <= 128'd1) begin
                        num_vectors++;
                end
        endtask

        // idle outputs must not move between blocks
        task automatic check_hold;
                if (done !== prev_done) begin
                        $display("[FAIL] done: got %h expected %h while idle", done, prev_done);
                        value_errors++;
                end
                if (prev_done && out_data !== held_data) begin
                        $display("[FAIL] out_data: got %h expected %h while idle",
                                 out_data, held_data);
                        value_errors++;
                end
        endtask

        task automatic idle_gap;
                int gap;
                gap = {$random(seed)} % 8;
                repeat (gap) begin
                        @(posedge clk);
                        @(negedge clk);
                        check_hold();
                end
        endtask

        initial begin
                int v;
                int n;
                logic got;
                logic aborted;
                logic [aes_pkg::block_bits-1:0] exp_pt;

                rst = 1'b1;
                read_en = 1'b0;
                data = '0;
                key = '0;
                seed = 32'h09e0df26;
                value_errors = 0;
                timing_errors = 0;
                other_errors = 0;
                prev_done = 1'b0;
                held_data = '0;
                aborted = 1'b0;
                load_trace();
                loaded = 1'b1;
                if (num_vectors == 0) begin
                        $display("no test vectors were found in the trace file");
                        other_errors++;
                end
                repeat (2) @(posedge clk);
                rst <= 1'b0;
                v = 0;
                while (v < num_vectors && !aborted) begin
                        idle_gap();
                        @(posedge clk);
                        read_en <= 1'b1;
                        key <= trace_mem[4*v];
                        data <= trace_mem[4*v + 1];
                        exp_pt = trace_mem[4*v + 2];
                        @(posedge clk);                 // read_en sampled here
                        read_en <= 1'b0;
                        @(negedge clk);
                        check_hold();
                        n = 0;
                        got = 1'b0;
                        while (!got && n < wait_limit) begin
                                @(posedge clk);
                                n++;
                                read_en <= 1'b0;
                                if (trace_mem[4*v + 3][0] && n == decoy_cycle - 1) begin
                                        read_en <= 1'b1;        // must be ignored mid-block
                                        key <= ~trace_mem[4*v];
                                        data <= ~trace_mem[4*v + 1];
                                end
                                @(negedge clk);
                                got = (done === 1'b1);
                        end
                        if (!got) begin
                                $display("done never rose within %0d cycles for vector %0d",
                                         wait_limit, v);
                                other_errors++;
                                aborted = 1'b1;
                        end else begin
                                if (n != latency) begin
                                        $display("[FAIL] done latency: got %h expected %h, vector %0d",
                                                 n, latency, v);
                                        timing_errors++;
                                end
                                if (out_data !== exp_pt) begin
                                        $display("[FAIL] out_data: got %h expected %h, vector %0d",
                                                 out_data, exp_pt, v);
                                        value_errors++;
                                end
                                prev_done = 1'b1;
                                held_data = exp_pt;
                        end
                        v++;
                end
                if (!aborted) begin
                        idle_gap();
                end
                $display("errors: %0d value, %0d timing, %0d other",
                         value_errors, timing_errors, other_errors);
                if (value_errors + timing_errors + other_errors == 0) begin
                        $display("Result: PASSED");
                end else begin
                        $display("Result: FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== testbench/aes_inv_trace.txt ====
// columns: key, ciphertext, expected plaintext, decoy flag (1 = spurious read_en mid-block)
// 128-bit values in hex with state byte 0 in the low byte
0f0e0d0c0b0a09080706050403020100 5ac5b47080b7cdd830047b6ad8e0c469 ffeeddccbbaa99887766554433221100 0
3c4fcf098815f7aba6d2ae2816157e2b 320b6a19978511dcfb09dc021d842539 340737e0a29831318d305a88a8f64332 1
00000000000000000000000000000000 2e2b34ca59fa4c883b2c8aefd44be966 00000000000000000000000000000000 0
3c4fcf098815f7aba6d2ae2816157e2b 97ef6624f3ca9ea860367a0db47bd73a 2a179373117e3de9969f402ee2bec16b 0
00000000000000000000000000000000 5e7f53cec97c565a59926d963e763603 e673f208fbc35dcdba27c63cec8144f3 1
3c4fcf098815f7aba6d2ae2816157e2b afbafd965a8985e79d69b90385d5d3f5 518eaf45ac6fb79e9cac031e578a2dae 0
00000000000000000000000000000000 8945237b9593c0eb546999f41b63a1a9 724e1710b97d22c3c775ad0b64c49897 1
3c4fcf098815f7aba6d2ae2816157e2b 880603ede3001b8823ce8e597fcdb143 ef520a1a19c1fbe511e45ca3461cc830 0
593847fb7c86cf74a3e54bd76988a510 6584f7dbb46faa4ee051b044691e256d 00000000000000000000000000000000 0
3c4fcf098815f7aba6d2ae2816157e2b d45d7204712023823fade8275e780c7b 10376ce67b412bad179b4fdf45249ff6 1

// ==== sim.f ====
source/aes_pkg.sv
source/aes_inv_mix_column.sv
source/aes_inv_round.sv
source/aes_key_expander.sv
source/aes_inv_control.sv
source/aes_result_stage.sv
source/aes_inv_top.sv
testbench/aes_inv_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = aes_inv_tb
FILELIST   = sim.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
